// File: hw/rvIsaPkg.sv
package rvIsaPkg;

    // Widths that carry a meaning
    typedef logic [31:0] word_t;     // Data, address and instruction word
    typedef logic [4:0]  regAddr_t;  // Register index x0..x31
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // Major opcodes, instr[6:0]
    localparam opcode_t opR      = 7'b0110011;
    localparam opcode_t opImm    = 7'b0010011;
    localparam opcode_t opLoad   = 7'b0000011;
    localparam opcode_t opStore  = 7'b0100011;
    localparam opcode_t opBranch = 7'b1100011;

    // funct3, instr[14:12]
    localparam funct3_t f3AddSub = 3'b000;
    localparam funct3_t f3Slt    = 3'b010;
    localparam funct3_t f3Or     = 3'b110;
    localparam funct3_t f3And    = 3'b111;
    localparam funct3_t f3Word   = 3'b010; // lw and sw
    localparam funct3_t f3Beq    = 3'b000;

    // Instruction bit that turns add into sub (funct7[5])
    localparam int f7Sub = 30;

    // addi x0, x0, 0
    localparam word_t nopInstr = 32'h0000_0013;

endpackage

// File: hw/rvCorePkg.sv
package rvCorePkg;

    // ALU function, picked by the decoder
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp_t;

    // Control word for one instruction
    typedef struct packed {
        logic   regWrite;  // Write rd at the edge
        logic   aluSrcImm; // Second operand is imm
        logic   memWrite;  // sw
        logic   memToReg;  // lw, writeback from memory
        logic   branch;    // beq
        aluOp_t aluOp;
    } ctrl_t;

    // No side effects at all
    localparam ctrl_t ctrlNone = '{
        regWrite:  1'b0,
        aluSrcImm: 1'b0,
        memWrite:  1'b0,
        memToReg:  1'b0,
        branch:    1'b0,
        aluOp:     aluAdd
    };

    // Memory sizes in words
    localparam int imemDepth = 64;
    localparam int dmemDepth = 64;

    // Word index into either memory
    typedef logic [$clog2(imemDepth)-1:0] memIndex_t;

endpackage

// File: hw/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit
    import rvIsaPkg::*, rvCorePkg::*;
(
    input  logic  CLK,
    input  logic  reset,
    input  logic  takeBranch,
    input  word_t branchTarget,
    output word_t pc,
    output word_t instr
);

    word_t     rom [imemDepth];
    word_t     nextPc;
    memIndex_t pcIndex;

    // Unused locations read back as nops
    initial begin
        for (int i = 0; i < imemDepth; i++) begin
            rom[i] = nopInstr;
        end
        $readmemh("program.hex", rom);
    end

    assign nextPc = takeBranch ? branchTarget : pc + 32'd4;

    always_ff @(posedge CLK) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    assign pcIndex = pc[$bits(memIndex_t)+1:2]; // Word address
    assign instr   = rom[pcIndex];

    // Branch offsets are only halfword aligned, so a bad beq could break this
    pcAligned: assert property (@(posedge CLK) disable iff (reset) pc[1:0] == 2'b00)
        else $error("PC misaligned: %h", pc);

    pcInRom: assert property (@(posedge CLK) disable iff (reset) pc < imemDepth * 4)
        else $error("PC beyond instruction ROM: %h", pc);

endmodule

// File: hw/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit
    import rvIsaPkg::*, rvCorePkg::*;
(
    input  word_t    instr,
    output ctrl_t    ctrl,
    output regAddr_t rs1,
    output regAddr_t rs2,
    output regAddr_t rd,
    output word_t    imm
);

    opcode_t opcode;
    funct3_t funct3;
    word_t   immI;
    word_t   immS;
    word_t   immB;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // Register fields sit at fixed positions in every format
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // Sign-extended immediates
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        ctrl = ctrlNone;
        imm  = '0;
        case (opcode)
            opR: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    f3AddSub: ctrl.aluOp = instr[f7Sub] ? aluSub : aluAdd;
                    f3Slt:    ctrl.aluOp = aluSlt;
                    f3Or:     ctrl.aluOp = aluOr;
                    f3And:    ctrl.aluOp = aluAnd;
                    default:  ctrl.regWrite = 1'b0; // Shifts and xor not supported
                endcase
            end
            opImm: begin
                // Only addi
                ctrl.regWrite  = (funct3 == f3AddSub);
                ctrl.aluSrcImm = 1'b1;
                imm            = immI;
            end
            opLoad: begin
                ctrl.regWrite  = (funct3 == f3Word); // lw only
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg  = 1'b1;
                imm            = immI;
            end
            opStore: begin
                ctrl.memWrite  = (funct3 == f3Word); // sw only
                ctrl.aluSrcImm = 1'b1;
                imm            = immS;
            end
            opBranch: begin
                ctrl.branch = (funct3 == f3Beq);
                ctrl.aluOp  = aluSub; // Zero flag means equal
                imm         = immB;
            end
            default: begin
                ctrl = ctrlNone; // Unknown opcode has no effect
            end
        endcase
    end

endmodule

// File: hw/registerFile.sv
`timescale 1ns/1ps

module registerFile
    import rvIsaPkg::*;
(
    input  logic     CLK,
    input  logic     reset,
    input  logic     writeEnable,
    input  regAddr_t rs1,
    input  regAddr_t rs2,
    input  regAddr_t rd,
    input  word_t    writeData,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [32];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && rd != '0) begin
            regs[rd] <= writeData; // x0 stays zero
        end
    end

    // Combinational reads, no bypass needed in a single-cycle core
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

// File: hw/executeUnit.sv
`timescale 1ns/1ps

module executeUnit
    import rvIsaPkg::*, rvCorePkg::*;
(
    input  ctrl_t ctrl,
    input  word_t pc,
    input  word_t rdata1,
    input  word_t rdata2,
    input  word_t imm,
    output word_t aluResult,
    output logic  takeBranch,
    output word_t branchTarget
);

    word_t operandB;
    logic  zero;

    assign operandB = ctrl.aluSrcImm ? imm : rdata2;

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluResult = rdata1 + operandB;
            aluSub:  aluResult = rdata1 - operandB;
            aluAnd:  aluResult = rdata1 & operandB;
            aluOr:   aluResult = rdata1 | operandB;
            aluSlt: begin
                // Signed compare
                aluResult = {31'b0, $signed(rdata1) < $signed(operandB)};
            end
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // beq resolves in the same cycle
    assign takeBranch   = ctrl.branch & zero;
    assign branchTarget = pc + imm;

endmodule

// File: hw/dataMemory.sv
`timescale 1ns/1ps

module dataMemory
    import rvIsaPkg::*, rvCorePkg::*;
(
    input  logic  CLK,
    input  logic  writeEnable,
    input  word_t addr,
    input  word_t writeData,
    output word_t readData
);

    word_t     mem [dmemDepth];
    memIndex_t index;

    assign index = addr[$bits(memIndex_t)+1:2]; // Byte address to word index

    always_ff @(posedge CLK) begin
        if (writeEnable) begin
            mem[index] <= writeData;
        end
    end

    assign readData = mem[index]; // Async read for lw

    storeAligned: assert property (@(posedge CLK) writeEnable |-> addr[1:0] == 2'b00)
        else $error("Misaligned store to %h", addr);

    storeInRange: assert property (@(posedge CLK) writeEnable |-> addr < dmemDepth * 4)
        else $error("Store beyond data memory: %h", addr);

endmodule

// File: hw/rvCore.sv
`timescale 1ns/1ps

module rvCore
    import rvIsaPkg::*, rvCorePkg::*;
(
    input  logic     CLK,
    input  logic     reset,
    output word_t    instr,
    output word_t    pc,
    output logic     retireRegWrite,
    output regAddr_t retireRd,
    output word_t    retireData,
    output logic     memWrite,
    output word_t    memAddr,
    output word_t    memData
);

    ctrl_t    ctrl;
    regAddr_t rs1;
    regAddr_t rs2;
    regAddr_t rd;
    word_t    imm;
    word_t    rdata1;
    word_t    rdata2;
    word_t    aluResult;
    logic     takeBranch;
    word_t    branchTarget;
    word_t    loadData;
    word_t    writeData;

    fetchUnit fetchUnit_inst (
        .CLK          (CLK),
        .reset        (reset),
        .takeBranch   (takeBranch),
        .branchTarget (branchTarget),
        .pc           (pc),
        .instr        (instr)
    );

    decodeUnit decodeUnit_inst (
        .instr (instr),
        .ctrl  (ctrl),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .imm   (imm)
    );

    registerFile registerFile_inst (
        .CLK         (CLK),
        .reset       (reset),
        .writeEnable (retireRegWrite),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .writeData   (writeData),
        .rdata1      (rdata1),
        .rdata2      (rdata2)
    );

    executeUnit executeUnit_inst (
        .ctrl         (ctrl),
        .pc           (pc),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .imm          (imm),
        .aluResult    (aluResult),
        .takeBranch   (takeBranch),
        .branchTarget (branchTarget)
    );

    dataMemory dataMemory_inst (
        .CLK         (CLK),
        .writeEnable (memWrite),
        .addr        (aluResult),
        .writeData   (rdata2),
        .readData    (loadData)
    );

    // Writeback select
    assign writeData = ctrl.memToReg ? loadData : aluResult;

    // No commits while reset is held
    assign retireRegWrite = ctrl.regWrite & ~reset;
    assign memWrite       = ctrl.memWrite & ~reset;

    // Observation ports for the retiring instruction
    assign retireRd   = rd;
    assign retireData = writeData;
    assign memAddr    = aluResult;
    assign memData    = rdata2;

endmodule

// File: verification/rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb
    import rvIsaPkg::*;
();

    localparam int halfPeriod  = 10; // 20 ns clock
    localparam int sampleDelay = 5;  // Quarter cycle after the falling edge
    localparam int resetCycles = 3;
    localparam int cycleLimit  = 200; // Roughly five times the program length

    // Expected effect of one instruction
    typedef struct packed {
        word_t    nextPc;
        logic     regWrite;
        regAddr_t rd;
        word_t    regData;
        logic     memWrite;
        word_t    memAddr;
        word_t    memData;
    } step_t;

    logic     CLK   = 1'b0;
    logic     reset = 1'b1;
    word_t    instr;
    word_t    pc;
    logic     retireRegWrite;
    regAddr_t retireRd;
    word_t    retireData;
    logic     memWrite;
    word_t    memAddr;
    word_t    memData;

    word_t progMem [64];   // Copy of the instruction ROM
    word_t modelRegs [32];
    word_t modelMem [64];
    word_t modelPc;
    step_t expected;
    logic  selfLoop;
    logic  finished;
    int    errors  = 0;
    int    checked = 0;
    int    cycles  = 0;

    rvCore rvCore_inst (
        .CLK            (CLK),
        .reset          (reset),
        .instr          (instr),
        .pc             (pc),
        .retireRegWrite (retireRegWrite),
        .retireRd       (retireRd),
        .retireData     (retireData),
        .memWrite       (memWrite),
        .memAddr        (memAddr),
        .memData        (memData)
    );

    initial begin
        forever #(halfPeriod) CLK = ~CLK;
    end

    // Reference model, straight from the RV32I encoding rules
    function automatic step_t stepModel(word_t instrWord, word_t curPc);
        step_t s;
        word_t a;
        word_t b;
        word_t immI;
        word_t immS;
        word_t immB;
        word_t addr;

        a    = modelRegs[instrWord[19:15]];
        b    = modelRegs[instrWord[24:20]];
        immI = {{20{instrWord[31]}}, instrWord[31:20]};
        immS = {{20{instrWord[31]}}, instrWord[31:25], instrWord[11:7]};
        immB = {{19{instrWord[31]}}, instrWord[31], instrWord[7], instrWord[30:25],
                instrWord[11:8], 1'b0};
        s        = '0;
        s.nextPc = curPc + 32'd4;
        s.rd     = instrWord[11:7];
        case (instrWord[6:0])
            7'b0110011: begin // Register ALU ops
                s.regWrite = 1'b1;
                case (instrWord[14:12])
                    3'b000:  s.regData = instrWord[30] ? a - b : a + b;
                    3'b010:  s.regData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b110:  s.regData = a | b;
                    3'b111:  s.regData = a & b;
                    default: s.regWrite = 1'b0;
                endcase
            end
            7'b0010011: begin // addi
                s.regWrite = (instrWord[14:12] == 3'b000);
                s.regData  = a + immI;
            end
            7'b0000011: begin // lw
                addr       = a + immI;
                s.regWrite = (instrWord[14:12] == 3'b010);
                s.regData  = modelMem[addr[7:2]];
            end
            7'b0100011: begin // sw
                s.memWrite = (instrWord[14:12] == 3'b010);
                s.memAddr  = a + immS;
                s.memData  = b;
            end
            7'b1100011: begin
                // beq taken only on equal operands
                if (instrWord[14:12] == 3'b000 && a == b) s.nextPc = curPc + immB;
            end
            default: ;
        endcase
        return s;
    endfunction

    task automatic applyStep(step_t s);
        if (s.regWrite && s.rd != 5'd0) modelRegs[s.rd] = s.regData; // x0 never changes
        if (s.memWrite) modelMem[s.memAddr[7:2]] = s.memData;
        modelPc = s.nextPc;
    endtask

    task automatic reportMismatch(string testName, word_t expValue, word_t actValue);
        $display("Fail %s at pc %h: expected %h, actual %h",
                 testName, modelPc, expValue, actValue);
        errors++;
    endtask

    task automatic finishRun();
        $display("Cycles checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout: the core did not settle on its final self-branch in %0d cycles",
                     cycleLimit);
            errors++;
            finishRun();
        end
    end

    initial begin
        for (int i = 0; i < 64; i++) begin
            progMem[i] = 32'h0000_0013; // Empty ROM words read as nops
        end
        $readmemh("verification/program.hex", progMem);
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        modelPc  = '0;
        selfLoop = 1'b0;
        finished = 1'b0;

        // Reset spans three rising edges
        repeat (resetCycles) begin
            @(negedge CLK);
            if (pc !== 32'h0) reportMismatch("reset pc", 32'h0, pc);
            if (retireRegWrite !== 1'b0) begin
                reportMismatch("reset regWrite", 32'h0, {31'b0, retireRegWrite});
            end
            if (memWrite !== 1'b0) reportMismatch("reset memWrite", 32'h0, {31'b0, memWrite});
        end
        reset = 1'b0;

        while (!finished) begin
            #(sampleDelay);
            expected = stepModel(progMem[modelPc[7:2]], modelPc);
            checked++;
            if (pc !== modelPc) reportMismatch("pc", modelPc, pc);
            if (instr !== progMem[modelPc[7:2]]) begin
                reportMismatch("instr", progMem[modelPc[7:2]], instr);
            end
            if (retireRegWrite !== expected.regWrite) begin
                reportMismatch("regWrite", {31'b0, expected.regWrite}, {31'b0, retireRegWrite});
            end
            if (expected.regWrite && retireRd !== expected.rd) begin
                reportMismatch("rd", {27'b0, expected.rd}, {27'b0, retireRd});
            end
            if (expected.regWrite && retireData !== expected.regData) begin
                reportMismatch("writeback", expected.regData, retireData);
            end
            if (memWrite !== expected.memWrite) begin
                reportMismatch("memWrite", {31'b0, expected.memWrite}, {31'b0, memWrite});
            end
            if (expected.memWrite && memAddr !== expected.memAddr) begin
                reportMismatch("memAddr", expected.memAddr, memAddr);
            end
            if (expected.memWrite && memData !== expected.memData) begin
                reportMismatch("memData", expected.memData, memData);
            end
            if (selfLoop) begin
                finished = 1'b1; // pc held on the final beq
            end else begin
                selfLoop = (expected.nextPc == modelPc);
                applyStep(expected);
                @(negedge CLK);
            end
        end
        finishRun();
    end

endmodule

// File: verification/program.hex
// One 32-bit instruction word per line in hex, starting at address 0
// Text after each word is the assembly and the byte address
00000263 // 00 beq  x0, x0, +4    taken, no writes on the first cycle
00500093 // 04 addi x1, x0, 5
ffd00113 // 08 addi x2, x0, -3
002081b3 // 0c add  x3, x1, x2
40208233 // 10 sub  x4, x1, x2
0020f2b3 // 14 and  x5, x1, x2
0020e333 // 18 or   x6, x1, x2
001123b3 // 1c slt  x7, x2, x1    negative operand
0020a433 // 20 slt  x8, x1, x2
00708013 // 24 addi x0, x1, 7     write to x0
001004b3 // 28 add  x9, x0, x1
00402823 // 2c sw   x4, 16(x0)
00602a23 // 30 sw   x6, 20(x0)
01002503 // 34 lw   x10, 16(x0)
01402583 // 38 lw   x11, 20(x0)
00450463 // 3c beq  x10, x4, +8   taken
06300613 // 40 addi x12, x0, 99   skipped
00208463 // 44 beq  x1, x2, +8    not taken
fff00693 // 48 addi x13, x0, -1
02800713 // 4c addi x14, x0, 40
fed72e23 // 50 sw   x13, -4(x14)
ffc72783 // 54 lw   x15, -4(x14)
40d78833 // 58 sub  x16, x15, x13
00080463 // 5c beq  x16, x0, +8   taken
00100893 // 60 addi x17, x0, 1    skipped
0006a933 // 64 slt  x18, x13, x0
003969b3 // 68 or   x19, x18, x3
00b9fa33 // 6c and  x20, x19, x11
00000063 // 70 beq  x0, x0, 0     self-branch

// File: tb.f
hw/rvIsaPkg.sv
hw/rvCorePkg.sv
hw/fetchUnit.sv
hw/decodeUnit.sv
hw/registerFile.sv
hw/executeUnit.sv
hw/dataMemory.sv
hw/rvCore.sv
verification/rvCoreTb.sv

// File: run.sh
#!/bin/sh
# The instruction ROM opens program.hex in the run directory, so a copy sits in the root
cp verification/program.hex program.hex &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module rvCoreTb \
    -f tb.f -o rvCoreSim > build.log 2>&1 &&
./obj_dir/rvCoreSim > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -qx "NO ERRORS" sim.log && exit 0 || exit 1
